// File: logic/rvPkg.sv
/* RV32I shared definitions
   Word type, major opcodes and the decoder's ALU class and immediate format */

package rvPkg;

    typedef logic [31:0] word;               // Data, address and instruction width

    // Major opcodes, instr[6:0]
    localparam logic [6:0] opLoad   = 7'b0000011;
    localparam logic [6:0] opStore  = 7'b0100011;
    localparam logic [6:0] opOpImm  = 7'b0010011;
    localparam logic [6:0] opOp     = 7'b0110011;
    localparam logic [6:0] opBranch = 7'b1100011;
    localparam logic [6:0] opJal    = 7'b1101111;
    localparam logic [6:0] opJalr   = 7'b1100111;
    localparam logic [6:0] opAuipc  = 7'b0010111;
    localparam logic [6:0] opLui    = 7'b0110111;

    // ALU operation class from main decode to ALU decode
    typedef enum logic [1:0] {
        classAdd,                            // Address, jump, upper immediate
        classBranch,                         // Subtract for compare
        classReg,                            // R-type, funct3 plus funct7[5]
        classImm                             // I-type, funct7[5] only on right shifts
    } aluClass;

    // Immediate layouts
    typedef enum logic [2:0] {
        fmtI,
        fmtS,
        fmtB,
        fmtU,
        fmtJ
    } immFormat;

endpackage : rvPkg

// File: logic/rvDecoder.sv
/* RV32I control decoder
   Main decode on opcode, then ALU decode on class and funct fields */

`timescale 1ns/1ns

module rvDecoder (
    input  logic [6:0]      opcode,
    input  logic [2:0]      funct3,
    input  logic [6:0]      funct7,
    output logic            regWrite,
    output logic            aluSrc,
    output logic            branch,
    output logic            memWrite,
    output logic            memToReg,
    output logic            jump,
    output logic            jalr,
    output logic            auipc,
    output logic            lui,
    output logic [2:0]      aluControl,
    output logic            aluSub,
    output rvPkg::immFormat immSel
);

    logic [8:0]     controls;
    rvPkg::aluClass aluCls;

    assign {regWrite, aluSrc, branch, memWrite, memToReg, jump, jalr, auipc, lui} = controls;

    // Main decode
    always_comb begin
        case (opcode)
            rvPkg::opOp:     begin controls = 9'b100000000; aluCls = rvPkg::classReg;    end
            rvPkg::opLoad:   begin controls = 9'b110010000; aluCls = rvPkg::classAdd;    end
            rvPkg::opStore:  begin controls = 9'b010100000; aluCls = rvPkg::classAdd;    end
            rvPkg::opOpImm:  begin controls = 9'b110000000; aluCls = rvPkg::classImm;    end
            rvPkg::opBranch: begin controls = 9'b001000000; aluCls = rvPkg::classBranch; end
            rvPkg::opJal:    begin controls = 9'b100001000; aluCls = rvPkg::classAdd;    end
            rvPkg::opJalr:   begin controls = 9'b110000100; aluCls = rvPkg::classAdd;    end
            rvPkg::opAuipc:  begin controls = 9'b110000010; aluCls = rvPkg::classAdd;    end
            rvPkg::opLui:    begin controls = 9'b110000001; aluCls = rvPkg::classAdd;    end
            default:         begin controls = 9'b000000000; aluCls = rvPkg::classAdd;    end
        endcase
    end

    // Immediate layout per opcode
    always_comb begin
        case (opcode)
            rvPkg::opStore:             immSel = rvPkg::fmtS;
            rvPkg::opBranch:            immSel = rvPkg::fmtB;
            rvPkg::opJal:               immSel = rvPkg::fmtJ;
            rvPkg::opAuipc, rvPkg::opLui: immSel = rvPkg::fmtU;
            default:                    immSel = rvPkg::fmtI; // Loads, OP-IMM, JALR
        endcase
    end

    // ALU decode
    always_comb begin
        case (aluCls)
            rvPkg::classAdd:    begin aluControl = 3'b000; aluSub = 1'b0; end
            rvPkg::classBranch: begin aluControl = 3'b000; aluSub = 1'b1; end
            rvPkg::classReg:    begin aluControl = funct3; aluSub = funct7[5]; end
            default: begin
                aluControl = funct3;
                aluSub     = (funct3 == 3'b101) && funct7[5]; // SRAI only, ADDI never subtracts
            end
        endcase
    end

    always_comb begin
        assert (!(memWrite && regWrite))
            else $error("Store also writes a register, class %s", aluCls.name());
        assert ($onehot0({branch, jump, jalr}))
            else $error("More than one PC redirect, class %s", aluCls.name());
    end

endmodule : rvDecoder

// File: logic/rvPcUnit.sv
/* Program counter unit
   Branch condition from ALU flags and next-PC selection for branch, JAL, JALR */

`timescale 1ns/1ns

module rvPcUnit #(
    parameter rvPkg::word ResetVector = 32'h0000_0000
) (
    input  logic       clk,
    input  logic       rst,
    input  logic       branch,
    input  logic       jump,
    input  logic       jalr,
    input  logic [2:0] funct3,
    input  logic       zero,
    input  logic       lessSigned,
    input  logic       lessUnsigned,
    input  rvPkg::word imm,
    input  rvPkg::word rs1Data,
    output rvPkg::word pc,
    output rvPkg::word pcPlus4
);

    logic       taken;
    rvPkg::word jalrTarget;
    rvPkg::word nextPc;

    always_comb begin
        case (funct3)
            3'b000:  taken = zero;           // BEQ
            3'b001:  taken = !zero;          // BNE
            3'b100:  taken = lessSigned;     // BLT
            3'b101:  taken = !lessSigned;    // BGE
            3'b110:  taken = lessUnsigned;   // BLTU
            3'b111:  taken = !lessUnsigned;  // BGEU
            default: taken = 1'b0;
        endcase
    end

    assign pcPlus4    = pc + 32'd4;
    assign jalrTarget = (rs1Data + imm) & ~32'd1;

    always_comb begin
        if (jalr)
            nextPc = jalrTarget;
        else if (jump || (branch && taken))
            nextPc = pc + imm;
        else
            nextPc = pcPlus4;
    end

    always_ff @(posedge clk) begin
        if (rst)
            pc <= ResetVector;
        else
            pc <= nextPc;
    end

    // Misaligned jump targets would show up here one edge later
    assert property (@(posedge clk) disable iff (rst) pc[1:0] == 2'b00)
        else $error("PC not word aligned: %h", pc);

endmodule : rvPcUnit

// File: logic/rvRegFile.sv
/* Integer register file, 32 x 32
   Two combinational read ports, one synchronous write port, x0 reads zero */

`timescale 1ns/1ns

module rvRegFile (
    input  logic       clk,
    input  logic       rst,
    input  logic [4:0] rs1,
    input  logic [4:0] rs2,
    input  logic [4:0] rd,
    input  logic       regWrite,
    input  rvPkg::word rdData,
    output rvPkg::word rs1Data,
    output rvPkg::word rs2Data
);

    rvPkg::word regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (regWrite && (rd != 5'd0)) begin
            regs[rd] <= rdData;                  // Writes to x0 dropped
        end
    end

    assign rs1Data = (rs1 == 5'd0) ? '0 : regs[rs1];
    assign rs2Data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule : rvRegFile

// File: logic/rvImmGen.sv
/* Immediate generator
   Reassembles and sign-extends the I, S, B, U and J immediate fields */

`timescale 1ns/1ns

module rvImmGen (
    input  rvPkg::word      instr,
    input  rvPkg::immFormat immSel,
    output rvPkg::word      imm
);

    logic sign;

    assign sign = instr[31];                 // Sign bit sits at 31 in every format

    always_comb begin
        case (immSel)
            rvPkg::fmtS: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            rvPkg::fmtB: imm = {{19{sign}}, instr[31], instr[7], instr[30:25],
                                instr[11:8], 1'b0};
            rvPkg::fmtU: imm = {instr[31:12], 12'b0};
            rvPkg::fmtJ: imm = {{11{sign}}, instr[31], instr[19:12], instr[20],
                                instr[30:21], 1'b0};
            default:     imm = {{20{sign}}, instr[31:20]}; // I-format
        endcase
    end

endmodule : rvImmGen

// File: logic/rvAlu.sv
/* RV32I ALU
   Add/sub, shifts, set-less-than and logic ops, plus compare flags for branches */

`timescale 1ns/1ns

module rvAlu (
    input  rvPkg::word a,
    input  rvPkg::word b,
    input  logic [2:0] aluControl,
    input  logic       aluSub,
    output rvPkg::word result,
    output logic       zero,
    output logic       lessSigned,
    output logic       lessUnsigned
);

    logic [4:0]         shamt;
    logic signed [31:0] aSigned;
    rvPkg::word         addSub;
    rvPkg::word         sraResult;

    assign shamt   = b[4:0];
    assign aSigned = a;

    assign addSub    = aluSub ? a - b : a + b;
    assign sraResult = aSigned >>> shamt;    // Kept apart so the shift stays arithmetic

    // Flags compare operands directly
    assign zero         = (a == b);
    assign lessSigned   = ($signed(a) < $signed(b));
    assign lessUnsigned = (a < b);

    always_comb begin
        case (aluControl)
            3'b000:  result = addSub;
            3'b001:  result = a << shamt;                     // SLL
            3'b010:  result = {31'b0, lessSigned};            // SLT
            3'b011:  result = {31'b0, lessUnsigned};          // SLTU
            3'b100:  result = a ^ b;
            3'b101:  result = aluSub ? sraResult : a >> shamt; // SRA / SRL
            3'b110:  result = a | b;
            default: result = a & b;
        endcase
    end

endmodule : rvAlu

// File: logic/rvCore.sv
/* Single-cycle RV32I core
   Decoder plus PC unit, register file, immediate generator and ALU */

`timescale 1ns/1ns

module rvCore #(
    parameter rvPkg::word ResetVector = 32'h0000_0000
) (
    input  logic       clk,
    input  logic       rst,
    output rvPkg::word instrAddr,
    input  rvPkg::word instr,
    output rvPkg::word dataAddr,
    output rvPkg::word writeData,
    output logic       memWrite,
    input  rvPkg::word readData
);

    logic            regWrite, aluSrc, branch, memWriteDec, memToReg;
    logic            jump, jalr, auipc, lui, aluSub;
    logic [2:0]      aluControl;
    rvPkg::immFormat immSel;
    rvPkg::word      pc, pcPlus4, imm, rs1Data, rs2Data;
    rvPkg::word      aluA, aluB, aluResult, rdData;
    logic            zero, lessSigned, lessUnsigned;

    rvDecoder decoder_inst (
        .opcode(instr[6:0]), .funct3(instr[14:12]), .funct7(instr[31:25]),
        .regWrite(regWrite), .aluSrc(aluSrc), .branch(branch),
        .memWrite(memWriteDec), .memToReg(memToReg),
        .jump(jump), .jalr(jalr), .auipc(auipc), .lui(lui),
        .aluControl(aluControl), .aluSub(aluSub), .immSel(immSel)
    );

    rvPcUnit #(.ResetVector(ResetVector)) pcUnit_inst (
        .clk(clk), .rst(rst),
        .branch(branch), .jump(jump), .jalr(jalr), .funct3(instr[14:12]),
        .zero(zero), .lessSigned(lessSigned), .lessUnsigned(lessUnsigned),
        .imm(imm), .rs1Data(rs1Data),
        .pc(pc), .pcPlus4(pcPlus4)
    );

    rvRegFile regFile_inst (
        .clk(clk), .rst(rst),
        .rs1(instr[19:15]), .rs2(instr[24:20]), .rd(instr[11:7]),
        .regWrite(regWrite), .rdData(rdData),
        .rs1Data(rs1Data), .rs2Data(rs2Data)
    );

    rvImmGen immGen_inst (.instr(instr), .immSel(immSel), .imm(imm));

    rvAlu alu_inst (
        .a(aluA), .b(aluB), .aluControl(aluControl), .aluSub(aluSub),
        .result(aluResult), .zero(zero),
        .lessSigned(lessSigned), .lessUnsigned(lessUnsigned)
    );

    assign aluA = auipc ? pc : (lui ? '0 : rs1Data);   // AUIPC adds PC, LUI adds zero
    assign aluB = aluSrc ? imm : rs2Data;

    assign rdData = (jump || jalr) ? pcPlus4 : (memToReg ? readData : aluResult);

    assign instrAddr = pc;
    assign dataAddr  = aluResult;
    assign writeData = rs2Data;
    assign memWrite  = memWriteDec && !rst;              // No stores while in reset

endmodule : rvCore

// File: dv/rvCoreTb.sv
/* Testbench for the single-cycle RV32I core
   Runs a program table and checks every store against an expected table */

`timescale 1ns/1ns

module rvCoreTb;

    logic       clk;
    logic       rst;
    rvPkg::word instrAddr;
    rvPkg::word instr;
    rvPkg::word dataAddr;
    rvPkg::word writeData;
    logic       memWrite;
    rvPkg::word readData;

    rvPkg::word prog [$];                    // Program at 0x100 upward
    rvPkg::word expAddr [$];
    rvPkg::word expData [$];
    rvPkg::word dmem [64];
    int         storeIdx;
    logic       storeInReset;                // Feed a store while rst is high

    localparam rvPkg::word nop     = 32'h0000_0013;
    localparam rvPkg::word loopPc  = 32'h0000_01F8; // Final self-loop JAL

    rvCore #(.ResetVector(32'h0000_0100)) rvCore_inst (
        .clk(clk), .rst(rst),
        .instrAddr(instrAddr), .instr(instr),
        .dataAddr(dataAddr), .writeData(writeData),
        .memWrite(memWrite), .readData(readData)
    );

    // Small assembler for the program table
    function automatic rvPkg::word rType(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, rvPkg::opOp};
    endfunction

    function automatic rvPkg::word iType(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic rvPkg::word sType(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rvPkg::opStore};
    endfunction

    function automatic rvPkg::word bType(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], rvPkg::opBranch};
    endfunction

    function automatic rvPkg::word jType(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvPkg::opJal};
    endfunction

    function automatic rvPkg::word uType(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic rvPkg::word fetch(input rvPkg::word addr);
        rvPkg::word idx;
        idx = (addr - 32'h100) >> 2;
        if (addr < 32'h100 || idx >= prog.size())
            return nop;
        return prog[idx];
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic checkWord(input string name, input rvPkg::word exp, input rvPkg::word act);
        if (exp !== act)
            failRun($sformatf("ERR %s expected %h actual %h", name, exp, act));
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (exp !== act)
            failRun($sformatf("ERR %s expected %b actual %b", name, exp, act));
    endtask

    task automatic expectStore(input rvPkg::word addr, input rvPkg::word data);
        expAddr.push_back(addr);
        expData.push_back(data);
    endtask

    task automatic buildProgram();
        // Arithmetic, x1 = 5, x2 = -3
        prog.push_back(iType(12'd5, 5'd0, 3'b000, 5'd1, rvPkg::opOpImm));
        prog.push_back(iType(-12'sd3, 5'd0, 3'b000, 5'd2, rvPkg::opOpImm));
        prog.push_back(rType(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));       // add
        prog.push_back(sType(12'h000, 5'd3, 5'd0));
        prog.push_back(rType(7'h20, 5'd2, 5'd1, 3'b000, 5'd4));       // sub
        prog.push_back(sType(12'h004, 5'd4, 5'd0));
        prog.push_back(iType({7'h20, 5'd1}, 5'd2, 3'b101, 5'd5, rvPkg::opOpImm)); // srai
        prog.push_back(sType(12'h008, 5'd5, 5'd0));
        prog.push_back(rType(7'h00, 5'd1, 5'd2, 3'b101, 5'd6));       // srl
        prog.push_back(sType(12'h00C, 5'd6, 5'd0));
        prog.push_back(rType(7'h00, 5'd1, 5'd2, 3'b010, 5'd7));       // slt
        prog.push_back(sType(12'h010, 5'd7, 5'd0));
        prog.push_back(rType(7'h00, 5'd1, 5'd2, 3'b011, 5'd8));       // sltu
        prog.push_back(sType(12'h014, 5'd8, 5'd0));
        prog.push_back(iType(12'h00F, 5'd1, 3'b100, 5'd9, rvPkg::opOpImm)); // xori
        prog.push_back(sType(12'h018, 5'd9, 5'd0));
        prog.push_back(rType(7'h00, 5'd1, 5'd1, 3'b001, 5'd10));      // sll
        prog.push_back(sType(12'h01C, 5'd10, 5'd0));
        prog.push_back(rType(7'h20, 5'd1, 5'd2, 3'b101, 5'd11));      // sra
        prog.push_back(sType(12'h020, 5'd11, 5'd0));
        // Load/store round trip with negative offsets
        prog.push_back(iType(12'd64, 5'd0, 3'b000, 5'd12, rvPkg::opOpImm));
        prog.push_back(sType(-12'sd4, 5'd4, 5'd12));
        prog.push_back(iType(-12'sd4, 5'd12, 3'b010, 5'd13, rvPkg::opLoad));
        prog.push_back(sType(12'h024, 5'd13, 5'd0));
        // Branches: taken one skips a store, fall-through one reaches it
        for (int b = 0; b < 6; b++) begin
            logic [2:0] f3;
            logic [4:0] tA, tB;
            case (b)
                0: begin f3 = 3'b000; tA = 5'd1; tB = 5'd1; end
                1: begin f3 = 3'b001; tA = 5'd1; tB = 5'd2; end
                2: begin f3 = 3'b100; tA = 5'd2; tB = 5'd1; end
                3: begin f3 = 3'b101; tA = 5'd1; tB = 5'd2; end
                4: begin f3 = 3'b110; tA = 5'd1; tB = 5'd2; end
                default: begin f3 = 3'b111; tA = 5'd2; tB = 5'd1; end
            endcase
            prog.push_back(bType(f3, tA, tB, 13'd8));
            prog.push_back(sType(12'h0F0, 5'd1, 5'd0));                // Must be skipped
            prog.push_back(bType(f3, tB, tA, 13'd8));                  // Operands swapped
            if (b == 0 || b == 1)
                prog[prog.size() - 1] = bType(f3, 5'd1, (b == 0) ? 5'd2 : 5'd1, 13'd8);
            prog.push_back(sType(12'h040 + 12'(b * 4), 5'd1, 5'd0));
        end
        // Jumps and upper immediates, starting at 0x1C0
        prog.push_back(jType(21'd8, 5'd14));
        prog.push_back(sType(12'h0F0, 5'd1, 5'd0));
        prog.push_back(sType(12'h058, 5'd14, 5'd0));
        prog.push_back(iType(12'h1DD, 5'd0, 3'b000, 5'd15, rvPkg::opOpImm)); // Odd target
        prog.push_back(iType(12'h000, 5'd15, 3'b000, 5'd16, rvPkg::opJalr));
        prog.push_back(sType(12'h0F0, 5'd1, 5'd0));
        prog.push_back(sType(12'h0F0, 5'd1, 5'd0));
        prog.push_back(sType(12'h05C, 5'd16, 5'd0));
        prog.push_back(uType(20'h12345, 5'd17, rvPkg::opLui));
        prog.push_back(sType(12'h060, 5'd17, 5'd0));
        prog.push_back(uType(20'h00001, 5'd18, rvPkg::opAuipc));
        prog.push_back(sType(12'h064, 5'd18, 5'd0));
        // x0 stays zero
        prog.push_back(iType(12'd7, 5'd0, 3'b000, 5'd0, rvPkg::opOpImm));
        prog.push_back(sType(12'h068, 5'd0, 5'd0));
        prog.push_back(jType(21'd0, 5'd0));                            // Self loop at 0x1F8
    endtask

    task automatic buildExpected();
        expectStore(32'h00, 32'h0000_0002);
        expectStore(32'h04, 32'h0000_0008);
        expectStore(32'h08, 32'hFFFF_FFFE);
        expectStore(32'h0C, 32'h07FF_FFFF);
        expectStore(32'h10, 32'h0000_0001);
        expectStore(32'h14, 32'h0000_0000);
        expectStore(32'h18, 32'h0000_000A);
        expectStore(32'h1C, 32'h0000_00A0);
        expectStore(32'h20, 32'hFFFF_FFFF);
        expectStore(32'h3C, 32'h0000_0008);
        expectStore(32'h24, 32'h0000_0008);
        for (int b = 0; b < 6; b++)
            expectStore(32'h40 + b * 4, 32'h0000_0005);
        expectStore(32'h58, 32'h0000_01C4);                            // JAL link
        expectStore(32'h5C, 32'h0000_01D4);                            // JALR link
        expectStore(32'h60, 32'h1234_5000);
        expectStore(32'h64, 32'h0000_11E8);                            // 0x1E8 + 0x1000
        expectStore(32'h68, 32'h0000_0000);
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    assign readData = dmem[dataAddr[7:2]];

    always @(posedge clk) begin
        #1;
        if (storeInReset)
            instr = sType(12'h0F0, 5'd1, 5'd0);                        // Must not reach memory
        else
            instr = fetch(instrAddr);
    end

    // Stores sampled mid-cycle, where the core's outputs are settled
    always @(negedge clk) begin
        if (memWrite) begin
            if (storeIdx >= expAddr.size()) begin
                failRun($sformatf("Unexpected extra store to %h of %h", dataAddr, writeData));
            end else begin
                checkWord($sformatf("store %0d address", storeIdx), expAddr[storeIdx], dataAddr);
                checkWord($sformatf("store %0d data", storeIdx), expData[storeIdx], writeData);
                dmem[dataAddr[7:2]] = writeData;
                storeIdx++;
            end
        end
    end

    initial begin
        int cycles;
        rst          = 1'b1;
        instr        = nop;
        storeInReset = 1'b1;
        storeIdx     = 0;
        for (int i = 0; i < 64; i++)
            dmem[i] = 32'hDEAD_0000 | (i * 4);
        buildProgram();
        buildExpected();

        @(negedge clk);
        checkWord("reset pc", 32'h100, instrAddr);
        checkBit("reset memWrite", 1'b0, memWrite);
        @(negedge clk);
        checkWord("reset pc", 32'h100, instrAddr);
        checkBit("reset memWrite", 1'b0, memWrite);
        storeInReset = 1'b0;
        @(posedge clk);
        #1 rst = 1'b0;
        @(negedge clk);
        checkWord("pc after reset", 32'h100, instrAddr);

        cycles = 0;
        while (instrAddr !== loopPc) begin
            @(negedge clk);
            cycles++;
            if (cycles > 200)
                failRun("Timeout: the core never reached the final self loop");
        end

        if (storeIdx != expAddr.size()) begin
            failRun($sformatf("Only %0d of %0d expected stores were seen",
                              storeIdx, expAddr.size()));
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule : rvCoreTb

// File: verilog.f
logic/rvPkg.sv
logic/rvDecoder.sv
logic/rvPcUnit.sv
logic/rvRegFile.sv
logic/rvImmGen.sv
logic/rvAlu.sv
logic/rvCore.sv
dv/rvCoreTb.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f verilog.f --top-module rvCoreTb -o rvCoreSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/rvCoreSim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF "*** PASSED ***"; then
    exit 0
fi
exit 1
